/* rtl/axil_pkg.sv */
/*
 * AXI-lite field widths, types and channel structs shared by the monitor.
 * Address 28 bits and data 32 bits, one strobe bit per data byte.
 */
package axil_pkg;

	////////////////////
	// Bus widths
	////////////////////
	localparam int ADDR_W = 28;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Field types
	typedef logic [ADDR_W-1:0] axil_addr_t;
	typedef logic [DATA_W-1:0] axil_data_t;
	typedef logic [STRB_W-1:0] axil_strb_t;
	typedef logic [2:0]        axil_prot_t;
	typedef logic [1:0]        axil_resp_t;

	// Exclusive-okay has no meaning on AXI-lite
	localparam axil_resp_t RESP_EXOKAY = 2'b01;

	////////////////////
	// Channel structs
	////////////////////

	// Write address
	typedef struct packed {
		logic       valid;
		logic       ready;
		axil_addr_t addr;
		axil_prot_t prot;
	} axil_aw_t;

	// Write data
	typedef struct packed {
		logic       valid;
		logic       ready;
		axil_data_t data;
		axil_strb_t strb;
	} axil_w_t;

	// Write response
	typedef struct packed {
		logic       valid;
		logic       ready;
		axil_resp_t resp;
	} axil_b_t;

	// Read address
	typedef struct packed {
		logic       valid;
		logic       ready;
		axil_addr_t addr;
		axil_prot_t prot;
	} axil_ar_t;

	// Read data
	typedef struct packed {
		logic       valid;
		logic       ready;
		axil_data_t data;
		axil_resp_t resp;
	} axil_r_t;

endpackage

/* rtl/monitor_pkg.sv */
/*
 * Monitor limits, counter and timer types, and the violation flag layout.
 * Counts saturate at CNT_FULL, so at most 15 requests can be tracked.
 */
package monitor_pkg;

	////////////////////
	// Outstanding counts
	////////////////////
	localparam int CNT_W = 4;
	typedef logic [CNT_W-1:0] out_cnt_t;
	localparam out_cnt_t CNT_FULL = '1;

	////////////////////
	// Protocol limits
	////////////////////

	// Longest allowed stall on any channel
	localparam int MAX_WAIT  = 12;
	// Longest wait for a response
	localparam int MAX_DELAY = 12;
	// Shortest allowed reset, in cycles
	localparam int MIN_RESET = 15;

	// Timers also measure reset length, so all three limits must fit
	localparam int LIMIT_TOP = (MAX_WAIT > MAX_DELAY) ? MAX_WAIT : MAX_DELAY;
	localparam int LIMIT_ALL = (LIMIT_TOP > MIN_RESET) ? LIMIT_TOP : MIN_RESET;
	localparam int TIMER_W   = $clog2(LIMIT_ALL + 1);
	typedef logic [TIMER_W-1:0] timer_t;

	// Sticky flags, short_reset in the top bit
	typedef struct packed {
		logic short_reset;
		logic valid_after_reset;
		logic bad_resp;
		logic unstable;
		logic request_stall;
		logic response_stall;
		logic count_overflow;
		logic orphan_response;
		logic write_latency;
		logic read_latency;
	} violation_t;

endpackage

/* rtl/reset_rule_checker.sv */
/*
 * Flags a reset shorter than MIN_RESET cycles and any valid seen on the
 * first cycle after reset. Both flags are one-cycle pulses at release.
 */
`timescale 1ns/1ns

module reset_rule_checker (
	input  logic       i_clk,
	input  logic       i_axi_reset_n,
	// AW, W, B, AR and R valids from the top bit down
	input  logic [4:0] i_valids,
	output logic       o_short_reset,
	output logic       o_valid_after_reset
);
	import monitor_pkg::*;

	timer_t rst_len;
	logic   rst_prev;
	logic   released;

	// Reset level one cycle ago
	always_ff @(posedge i_clk)
	begin
		rst_prev <= i_axi_reset_n;
	end

	// Length of the current reset, held once it reaches the minimum
	always_ff @(posedge i_clk)
	begin
		if (i_axi_reset_n)
			rst_len <= '0;
		else if (rst_len != timer_t'(MIN_RESET))
			rst_len <= rst_len + 1'b1;
	end

	// First cycle with reset high
	assign released = i_axi_reset_n && !rst_prev;

	// Count still short of the minimum when reset lets go
	assign o_short_reset = released && (rst_len < timer_t'(MIN_RESET));

	// No channel may present valid right out of reset
	assign o_valid_after_reset = released && (|i_valids);

endmodule

/* rtl/outstanding_tracker.sv */
/*
 * Counts AW, W and read requests that still wait for a response.
 * Counts saturate at CNT_FULL and at zero, so a flagged bus keeps sane counts.
 */
`timescale 1ns/1ns

module outstanding_tracker (
	input  logic                  i_clk,
	input  logic                  i_axi_reset_n,
	input  axil_pkg::axil_aw_t    i_aw,
	input  axil_pkg::axil_w_t     i_w,
	input  axil_pkg::axil_b_t     i_b,
	input  axil_pkg::axil_ar_t    i_ar,
	input  axil_pkg::axil_r_t     i_r,
	output monitor_pkg::out_cnt_t o_aw_cnt,
	output monitor_pkg::out_cnt_t o_w_cnt,
	output monitor_pkg::out_cnt_t o_rd_cnt,
	output logic                  o_overflow,
	output logic                  o_orphan
);
	import monitor_pkg::*;

	logic aw_req;
	logic w_req;
	logic ar_req;
	logic b_ack;
	logic r_ack;

	// One up/down step that holds the count when both happen together
	function automatic out_cnt_t step_cnt(input out_cnt_t cnt, input logic up,
			input logic down);
		out_cnt_t cnt_next;
		cnt_next = cnt;
		if (up && !down && (cnt != CNT_FULL))
			cnt_next = cnt + 1'b1;
		else if (down && !up && (cnt != '0))
			cnt_next = cnt - 1'b1;
		return cnt_next;
	endfunction

	////////////////////
	// Transfers
	////////////////////

	// A transfer needs valid and ready
	assign aw_req = i_aw.valid && i_aw.ready;
	assign w_req  = i_w.valid && i_w.ready;
	assign ar_req = i_ar.valid && i_ar.ready;
	assign b_ack  = i_b.valid && i_b.ready;
	assign r_ack  = i_r.valid && i_r.ready;

	////////////////////
	// Counters
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_aw_cnt <= '0;
			o_w_cnt  <= '0;
			o_rd_cnt <= '0;
		end
		else
		begin
			// One B retires both an address and a data beat
			o_aw_cnt <= step_cnt(o_aw_cnt, aw_req, b_ack);
			o_w_cnt  <= step_cnt(o_w_cnt, w_req, b_ack);
			o_rd_cnt <= step_cnt(o_rd_cnt, ar_req, r_ack);
		end
	end

	// Any counter at its top value
	assign o_overflow = (o_aw_cnt == CNT_FULL) || (o_w_cnt == CNT_FULL)
		|| (o_rd_cnt == CNT_FULL);

	// B needs both an address and a data beat in flight and R needs a read
	assign o_orphan = (i_b.valid && ((o_aw_cnt == '0) || (o_w_cnt == '0)))
		|| (i_r.valid && (o_rd_cnt == '0));

endmodule

/* rtl/handshake_rule_checker.sv */
/*
 * Watches one valid/ready channel for payload changes or a dropped valid
 * during a stall, and for stalls of MAX_WAIT cycles or more.
 */
`timescale 1ns/1ns

module handshake_rule_checker #(
	parameter int PAYLOAD_W = 8
) (
	input  logic                 i_clk,
	input  logic                 i_axi_reset_n,
	input  logic                 i_valid,
	input  logic                 i_ready,
	input  logic [PAYLOAD_W-1:0] i_payload,
	output logic                 o_unstable,
	output logic                 o_stall
);
	import monitor_pkg::*;

	logic [PAYLOAD_W-1:0] payload_q;
	logic                 stalled_q;
	logic                 stall;
	timer_t               stall_time;

	// Valid offered but not taken
	assign stall = i_valid && !i_ready;

	// Payload of the previous cycle
	always_ff @(posedge i_clk)
	begin
		payload_q <= i_payload;
	end

	// Whether the previous cycle was a stall
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			stalled_q <= 1'b0;
		else
			stalled_q <= stall;
	end

	// after a stall, valid must stay up and the payload must hold
	assign o_unstable = stalled_q && (!i_valid || (i_payload != payload_q));

	////////////////////
	// Stall timer
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || !stall)
			stall_time <= '0;
		else if (stall_time != timer_t'(MAX_WAIT))
			stall_time <= stall_time + 1'b1;
	end

	// Raised so the flag lands on the edge the timer reaches MAX_WAIT
	assign o_stall = stall && (stall_time == timer_t'(MAX_WAIT - 1));

endmodule

/* rtl/response_latency_checker.sv */
/*
 * Times how long outstanding writes and reads go without a response.
 * A held-back response (valid high) stops and clears its timer.
 */
`timescale 1ns/1ns

module response_latency_checker (
	input  logic                  i_clk,
	input  logic                  i_axi_reset_n,
	input  logic                  i_bvalid,
	input  logic                  i_rvalid,
	input  monitor_pkg::out_cnt_t i_aw_cnt,
	input  monitor_pkg::out_cnt_t i_w_cnt,
	input  monitor_pkg::out_cnt_t i_rd_cnt,
	output logic                  o_write_late,
	output logic                  o_read_late
);
	import monitor_pkg::*;

	logic   wr_wait;
	logic   rd_wait;
	timer_t wr_time;
	timer_t rd_time;

	// A write is complete once both address and data have gone out
	assign wr_wait = (i_aw_cnt != '0) && (i_w_cnt != '0) && !i_bvalid;
	assign rd_wait = (i_rd_cnt != '0) && !i_rvalid;

	////////////////////
	// Write timer
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || !wr_wait)
			wr_time <= '0;
		else if (wr_time != timer_t'(MAX_DELAY))
			wr_time <= wr_time + 1'b1;
	end

	////////////////////
	// Read timer
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n || !rd_wait)
			rd_time <= '0;
		else if (rd_time != timer_t'(MAX_DELAY))
			rd_time <= rd_time + 1'b1;
	end

	// Flags line up with the edge where a timer reaches MAX_DELAY
	assign o_write_late = wr_wait && (wr_time == timer_t'(MAX_DELAY - 1));
	assign o_read_late  = rd_wait && (rd_time == timer_t'(MAX_DELAY - 1));

endmodule

/* rtl/axil_protocol_monitor.sv */
/*
 * Passive AXI-lite protocol monitor; it never drives the bus.
 * Flags are sticky until reset. short_reset is decided at each reset release.
 */
`timescale 1ns/1ns

module axil_protocol_monitor (
	input  logic                    i_clk,
	input  logic                    i_axi_reset_n,
	input  axil_pkg::axil_aw_t      i_aw,
	input  axil_pkg::axil_w_t       i_w,
	input  axil_pkg::axil_b_t       i_b,
	input  axil_pkg::axil_ar_t      i_ar,
	input  axil_pkg::axil_r_t       i_r,
	output monitor_pkg::violation_t o_violation,
	output monitor_pkg::out_cnt_t   o_aw_cnt,
	output monitor_pkg::out_cnt_t   o_w_cnt,
	output monitor_pkg::out_cnt_t   o_rd_cnt
);
	import axil_pkg::*;
	import monitor_pkg::*;

	// Channel order AW, W, B, AR, R from the top bit down
	logic [4:0] valids;
	logic [4:0] hs_unstable;
	logic [4:0] hs_stall;

	logic       short_reset;
	logic       valid_after_reset;
	logic       overflow;
	logic       orphan;
	logic       write_late;
	logic       read_late;
	logic       reset_q;
	violation_t viol_raw;

	assign valids = {i_aw.valid, i_w.valid, i_b.valid, i_ar.valid, i_r.valid};

	////////////////////
	// Checkers
	////////////////////
	reset_rule_checker u_reset (
		.i_clk               (i_clk),
		.i_axi_reset_n       (i_axi_reset_n),
		.i_valids            (valids),
		.o_short_reset       (short_reset),
		.o_valid_after_reset (valid_after_reset)
	);

	outstanding_tracker u_tracker (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_aw          (i_aw),
		.i_w           (i_w),
		.i_b           (i_b),
		.i_ar          (i_ar),
		.i_r           (i_r),
		.o_aw_cnt      (o_aw_cnt),
		.o_w_cnt       (o_w_cnt),
		.o_rd_cnt      (o_rd_cnt),
		.o_overflow    (overflow),
		.o_orphan      (orphan)
	);

	// Payload is every field but valid and ready
	handshake_rule_checker #(.PAYLOAD_W($bits(axil_aw_t) - 2)) u_aw_hs (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_valid       (i_aw.valid),
		.i_ready       (i_aw.ready),
		.i_payload     ({i_aw.addr, i_aw.prot}),
		.o_unstable    (hs_unstable[4]),
		.o_stall       (hs_stall[4])
	);

	handshake_rule_checker #(.PAYLOAD_W($bits(axil_w_t) - 2)) u_w_hs (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_valid       (i_w.valid),
		.i_ready       (i_w.ready),
		.i_payload     ({i_w.data, i_w.strb}),
		.o_unstable    (hs_unstable[3]),
		.o_stall       (hs_stall[3])
	);

	handshake_rule_checker #(.PAYLOAD_W($bits(axil_b_t) - 2)) u_b_hs (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_valid       (i_b.valid),
		.i_ready       (i_b.ready),
		.i_payload     (i_b.resp),
		.o_unstable    (hs_unstable[2]),
		.o_stall       (hs_stall[2])
	);

	handshake_rule_checker #(.PAYLOAD_W($bits(axil_ar_t) - 2)) u_ar_hs (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_valid       (i_ar.valid),
		.i_ready       (i_ar.ready),
		.i_payload     ({i_ar.addr, i_ar.prot}),
		.o_unstable    (hs_unstable[1]),
		.o_stall       (hs_stall[1])
	);

	handshake_rule_checker #(.PAYLOAD_W($bits(axil_r_t) - 2)) u_r_hs (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_valid       (i_r.valid),
		.i_ready       (i_r.ready),
		.i_payload     ({i_r.data, i_r.resp}),
		.o_unstable    (hs_unstable[0]),
		.o_stall       (hs_stall[0])
	);

	response_latency_checker u_latency (
		.i_clk         (i_clk),
		.i_axi_reset_n (i_axi_reset_n),
		.i_bvalid      (i_b.valid),
		.i_rvalid      (i_r.valid),
		.i_aw_cnt      (o_aw_cnt),
		.i_w_cnt       (o_w_cnt),
		.i_rd_cnt      (o_rd_cnt),
		.o_write_late  (write_late),
		.o_read_late   (read_late)
	);

	////////////////////
	// Raw flags
	////////////////////
	always_comb
	begin
		viol_raw.short_reset       = short_reset;
		viol_raw.valid_after_reset = valid_after_reset;
		// Exclusive-okay on any presented response
		viol_raw.bad_resp = (i_b.valid && (i_b.resp == RESP_EXOKAY))
			|| (i_r.valid && (i_r.resp == RESP_EXOKAY));
		viol_raw.unstable          = |hs_unstable;
		viol_raw.request_stall     = hs_stall[4] || hs_stall[3] || hs_stall[1];
		viol_raw.response_stall    = hs_stall[2] || hs_stall[0];
		viol_raw.count_overflow    = overflow;
		viol_raw.orphan_response   = orphan;
		viol_raw.write_latency     = write_late;
		viol_raw.read_latency      = read_late;
	end

	// Reset level one cycle ago, marks the release edge
	always_ff @(posedge i_clk)
	begin
		reset_q <= i_axi_reset_n;
	end

	////////////////////
	// Sticky flags
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			o_violation <= '0;
			// Kept through reset, judged again at release
			o_violation.short_reset <= o_violation.short_reset;
		end
		else
		begin
			o_violation <= o_violation | viol_raw;
			// a full reset clears it here, a short one sets it
			if (!reset_q)
				o_violation.short_reset <= viol_raw.short_reset;
		end
	end

endmodule

/* testbench/tb_axil_protocol_monitor.sv */
/*
 * Testbench for the AXI-lite protocol monitor, run from the project root.
 * Reads testbench/monitor_input.txt: S lines hold the bus for some cycles,
 * E lines check flags and counts after the last edge of the segment before.
 */
`timescale 1ns/1ns

module tb_axil_protocol_monitor;
	import axil_pkg::*;
	import monitor_pkg::*;

	// ASCII codes of the line tags
	localparam int CH_NL        = 10;
	localparam int CH_HASH      = 35;
	localparam int CH_EXP       = 69;
	localparam int CH_SEG       = 83;
	localparam int RESET_CYCLES = 16;

	// One line of the input file, a bus segment or a check
	typedef struct packed {
		logic        is_check;
		logic [15:0] repeat_n;
		logic        rst_n;
		axil_aw_t    aw;
		axil_w_t     w;
		axil_b_t     b;
		axil_ar_t    ar;
		axil_r_t     r;
		violation_t  exp_viol;
		out_cnt_t    exp_aw;
		out_cnt_t    exp_w;
		out_cnt_t    exp_rd;
	} step_t;

	logic       clk;
	logic       axi_reset_n;
	axil_aw_t   aw_ch;
	axil_w_t    w_ch;
	axil_b_t    b_ch;
	axil_ar_t   ar_ch;
	axil_r_t    r_ch;
	violation_t violation;
	out_cnt_t   aw_cnt;
	out_cnt_t   w_cnt;
	out_cnt_t   rd_cnt;

	step_t steps[$];
	int    errors = 0;
	int    checks = 0;
	int    cycle_cnt = 0;
	int    cycle_limit = 0;
	logic  load_ok;

	axil_protocol_monitor i_dut (
		.i_clk         (clk),
		.i_axi_reset_n (axi_reset_n),
		.i_aw          (aw_ch),
		.i_w           (w_ch),
		.i_b           (b_ch),
		.i_ar          (ar_ch),
		.i_r           (r_ch),
		.o_violation   (violation),
		.o_aw_cnt      (aw_cnt),
		.o_w_cnt       (w_cnt),
		.o_rd_cnt      (rd_cnt)
	);

	// 4 ns clock
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Watchdog, armed once the input file is loaded
	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if ((cycle_limit != 0) && (cycle_cnt >= cycle_limit))
		begin
			$display("Timeout: the run did not end within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////
	// Input file
	////////////////////
	task automatic load_steps(output logic ok);
		int          fd;
		int          c;
		int          n;
		int          n_rep;
		logic [31:0] fld [0:19];
		step_t       st;
		ok = 1'b1;
		fd = $fopen("testbench/monitor_input.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open testbench/monitor_input.txt");
			ok = 1'b0;
		end
		else
		begin
			c = $fgetc(fd);
			while (ok && (c != -1))
			begin
				st = '0;
				if (c == CH_HASH)
				begin
					// Comment runs to the end of the line
					while ((c != CH_NL) && (c != -1))
						c = $fgetc(fd);
				end
				else if (c == CH_SEG)
				begin
					n = $fscanf(fd, "%d", n_rep);
					for (int k = 0; k < 20; k++)
						n += $fscanf(fd, "%h", fld[k]);
					if (n != 21)
					begin
						$display("Malformed segment line in input file, %0d fields", n);
						ok = 1'b0;
					end
					st.repeat_n = n_rep[15:0];
					st.rst_n    = fld[0][0];
					st.aw = {fld[1][0], fld[2][0], fld[3][ADDR_W-1:0], fld[4][2:0]};
					st.w  = {fld[5][0], fld[6][0], fld[7][DATA_W-1:0], fld[8][STRB_W-1:0]};
					st.b  = {fld[9][0], fld[10][0], fld[11][1:0]};
					st.ar = {fld[12][0], fld[13][0], fld[14][ADDR_W-1:0], fld[15][2:0]};
					st.r  = {fld[16][0], fld[17][0], fld[18][DATA_W-1:0], fld[19][1:0]};
					steps.push_back(st);
				end
				else if (c == CH_EXP)
				begin
					n = $fscanf(fd, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
					if (n != 4)
					begin
						$display("Malformed check line in input file, %0d fields", n);
						ok = 1'b0;
					end
					st.is_check = 1'b1;
					st.exp_viol = fld[0][$bits(violation_t)-1:0];
					st.exp_aw   = fld[1][CNT_W-1:0];
					st.exp_w    = fld[2][CNT_W-1:0];
					st.exp_rd   = fld[3][CNT_W-1:0];
					steps.push_back(st);
				end
				else if (c > 32)
				begin
					$display("Unknown line tag in input file");
					ok = 1'b0;
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	////////////////////
	// Drive and check
	////////////////////

	// Holds one segment for its repeat count, driven 1 ns after each edge
	task automatic apply_segment(input step_t st);
		axi_reset_n = st.rst_n;
		aw_ch       = st.aw;
		w_ch        = st.w;
		b_ch        = st.b;
		ar_ch       = st.ar;
		r_ch        = st.r;
		repeat (st.repeat_n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic check_outputs(input step_t st);
		checks++;
		if (violation !== st.exp_viol)
		begin
			errors++;
			$display("** Error at %0t ns: flags %03h, expected %03h",
				$time, violation, st.exp_viol);
		end
		if (aw_cnt !== st.exp_aw)
		begin
			errors++;
			$display("** Error at %0t ns: aw count %0d, expected %0d", $time, aw_cnt, st.exp_aw);
		end
		if (w_cnt !== st.exp_w)
		begin
			errors++;
			$display("** Error at %0t ns: w count %0d, expected %0d", $time, w_cnt, st.exp_w);
		end
		if (rd_cnt !== st.exp_rd)
		begin
			errors++;
			$display("** Error at %0t ns: read count %0d, expected %0d", $time, rd_cnt, st.exp_rd);
		end
	endtask

	initial
	begin
		axi_reset_n = 1'b1;
		aw_ch       = '0;
		w_ch        = '0;
		b_ch        = '0;
		ar_ch       = '0;
		r_ch        = '0;
		load_steps(load_ok);
		if (!load_ok)
		begin
			$display("TEST FAILED");
			$finish;
		end
		else
		begin
			// Reset, every segment and some slack
			cycle_limit = RESET_CYCLES + 1 + 50;
			foreach (steps[k])
				cycle_limit += int'(steps[k].repeat_n);
			// One edge with reset high, so the reset length counter starts at zero
			@(posedge clk);
			#1;
			axi_reset_n = 1'b0;
			repeat (RESET_CYCLES)
				@(posedge clk);
			#1;
			// First segment releases reset
			foreach (steps[k])
			begin
				if (steps[k].is_check)
					check_outputs(steps[k]);
				else
					apply_segment(steps[k]);
			end
			$display("Checks: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("TEST OK");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

endmodule

/* testbench/monitor_input.txt */
# S cycles rst  aw:v r addr prot  w:v r data strb  b:v r resp  ar:v r addr prot  r:v r data resp
# E flags(hex, short_reset in bit 9) aw_cnt w_cnt rd_cnt, after the segment above
# 1: clean writes and reads, request and response in the same cycle
S 2 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  1 1 0000100 0  1 1 11223344 f  0 0 0  0 0 0000000 0  0 0 00000000 0
E 000 1 1 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  1 1 0  0 0 0000000 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  1 1 0000200 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  1 1 0000204 0  1 1 cafe0001 0
E 000 0 0 1
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  1 1 cafe0002 2
S 1 1  1 1 0000108 2  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  0 0 0000000 0  1 1 55667788 3  0 0 0  0 0 0000000 0  0 0 00000000 0
S 2 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  1 1 0  0 0 0000000 0  0 0 00000000 0
S 2 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
E 000 0 0 0
# 2: AW address changes while stalled, AR stalls 12 cycles, B stalls 12 cycles
S 16 0 0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 2 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 3 1  1 0 0000300 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  1 0 0000304 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  1 1 0000304 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
E 040 1 0 0
S 12 1 0 0 0000000 0  0 0 00000000 0  0 0 0  1 0 0000400 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  1 1 0000400 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  1 1 00000000 0
S 1 1  0 0 0000000 0  1 1 aabbccdd f  0 0 0  0 0 0000000 0  0 0 00000000 0
E 060 1 1 0
S 12 1 0 0 0000000 0  0 0 00000000 0  1 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  1 1 0  0 0 0000000 0  0 0 00000000 0
E 070 0 0 0
# 3: R with no read outstanding, then an exclusive-okay read response
S 16 0 0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 2 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  1 1 12345678 0
E 004 0 0 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  1 1 0000600 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  1 1 9abcdef0 1
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
E 084 0 0 0
# 4: 15 AW transfers with no response, then a read left waiting
S 16 0 0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 2 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 15 1 1 1 0000700 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  1 1 0000800 0  0 0 00000000 0
S 11 1 0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
E 008 f 0 1
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
E 009 f 0 1
# 5: 5-cycle reset, valid right after a full reset, then a clean full reset
S 5 0  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 2 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
E 200 0 0 0
S 16 0 0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
E 200 0 0 0
S 1 1  1 1 0000900 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 1 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
E 100 1 0 0
S 16 0 0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
S 2 1  0 0 0000000 0  0 0 00000000 0  0 0 0  0 0 0000000 0  0 0 00000000 0
E 000 0 0 0

/* compile.f */
rtl/axil_pkg.sv
rtl/monitor_pkg.sv
rtl/reset_rule_checker.sv
rtl/outstanding_tracker.sv
rtl/handshake_rule_checker.sv
rtl/response_latency_checker.sv
rtl/axil_protocol_monitor.sv
testbench/tb_axil_protocol_monitor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the monitor testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f compile.f \
	--top-module tb_axil_protocol_monitor -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "TEST OK" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
